//--- design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int word_w     = 32; // data and pc
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;
    localparam int alu_op_w   = 12;

    // one-hot alu operation bits
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

endpackage

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function field, special opcode only
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [4:0] reg_link = 5'd31; // jal writes here

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] jidx;
        } j;
    } inst_word_u;

endpackage

`default_nettype wire

//--- design/stage_ifs.sv
`default_nettype none

// decoder results, shared by bypass, branch and the stage outputs
interface decode_if;
    logic [pipe_pkg::alu_op_w-1:0]   alu_op;
    logic                            src1_is_sa;
    logic                            src1_is_pc;
    logic                            src2_is_imm;
    logic                            src2_is_8;
    logic                            mem_re;
    logic                            mem_we;
    logic                            gpr_we;
    logic [pipe_pkg::reg_addr_w-1:0] dest;
    logic                            uses_rs;
    logic                            uses_rt;
    logic                            is_beq;
    logic                            is_bne;
    logic                            is_j_imm; // j or jal
    logic                            is_jr;

    modport dec (
        output alu_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8,
               mem_re, mem_we, gpr_we, dest, uses_rs, uses_rt,
               is_beq, is_bne, is_j_imm, is_jr
    );
    modport sink (
        input alu_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8,
              mem_re, mem_we, gpr_we, dest, uses_rs, uses_rt,
              is_beq, is_bne, is_j_imm, is_jr
    );
endinterface

interface rf_read_if;
    logic [pipe_pkg::reg_addr_w-1:0] raddr1;
    logic [pipe_pkg::reg_addr_w-1:0] raddr2;
    logic [pipe_pkg::word_w-1:0]     rdata1;
    logic [pipe_pkg::word_w-1:0]     rdata2;

    modport reader (output raddr1, raddr2, input rdata1, rdata2);
    modport bank (input raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

//--- design/id_input_reg.sv
`default_nettype none

module id_input_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fs_to_ds_valid,
    input  logic [pipe_pkg::word_w-1:0] fs_inst,
    input  logic [pipe_pkg::word_w-1:0] fs_pc,
    input  logic                        ready_go,
    input  logic                        es_allowin,
    output logic                        ds_allowin,
    output logic                        ds_valid,
    output logic [pipe_pkg::word_w-1:0] ds_inst,
    output logic [pipe_pkg::word_w-1:0] ds_pc
);

    // empty, or the current word leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin // load on acceptance only
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  logic [pipe_pkg::word_w-1:0] ds_inst,
    decode_if.dec                       ctl
);

    isa_pkg::inst_word_u iw;
    logic is_special, sa_zero, rs_zero;
    logic inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic r_alu, i_alu, dst_is_rt;

    assign iw = ds_inst;

    assign is_special = iw.r.op == isa_pkg::op_special;
    assign sa_zero    = iw.r.sa == '0;
    assign rs_zero    = iw.r.rs == '0;

    // register-register ops need a zero shift field
    assign inst_addu = is_special && sa_zero && iw.r.func == isa_pkg::fn_addu;
    assign inst_subu = is_special && sa_zero && iw.r.func == isa_pkg::fn_subu;
    assign inst_and  = is_special && sa_zero && iw.r.func == isa_pkg::fn_and;
    assign inst_or   = is_special && sa_zero && iw.r.func == isa_pkg::fn_or;
    assign inst_xor  = is_special && sa_zero && iw.r.func == isa_pkg::fn_xor;
    assign inst_nor  = is_special && sa_zero && iw.r.func == isa_pkg::fn_nor;
    assign inst_slt  = is_special && sa_zero && iw.r.func == isa_pkg::fn_slt;
    assign inst_sltu = is_special && sa_zero && iw.r.func == isa_pkg::fn_sltu;
    // shifts by sa, rs unused
    assign inst_sll  = is_special && rs_zero && iw.r.func == isa_pkg::fn_sll;
    assign inst_srl  = is_special && rs_zero && iw.r.func == isa_pkg::fn_srl;
    assign inst_sra  = is_special && rs_zero && iw.r.func == isa_pkg::fn_sra;
    assign inst_jr   = is_special && sa_zero && iw.r.rt == '0 && iw.r.rd == '0
                     && iw.r.func == isa_pkg::fn_jr;

    assign inst_addiu = iw.i.op == isa_pkg::op_addiu;
    assign inst_andi  = iw.i.op == isa_pkg::op_andi;
    assign inst_ori   = iw.i.op == isa_pkg::op_ori;
    assign inst_xori  = iw.i.op == isa_pkg::op_xori;
    assign inst_lui   = iw.i.op == isa_pkg::op_lui && iw.i.rs == '0;
    assign inst_lw    = iw.i.op == isa_pkg::op_lw;
    assign inst_sw    = iw.i.op == isa_pkg::op_sw;
    assign inst_beq   = iw.i.op == isa_pkg::op_beq;
    assign inst_bne   = iw.i.op == isa_pkg::op_bne;
    assign inst_j     = iw.j.op == isa_pkg::op_j;
    assign inst_jal   = iw.j.op == isa_pkg::op_jal;

    assign r_alu = inst_addu | inst_subu | inst_and | inst_or | inst_xor | inst_nor
                 | inst_slt | inst_sltu;
    assign i_alu = inst_addiu | inst_andi | inst_ori | inst_xori;

    assign ctl.alu_op[pipe_pkg::alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw
                                          | inst_jal; // link is pc + 8
    assign ctl.alu_op[pipe_pkg::alu_sub]  = inst_subu;
    assign ctl.alu_op[pipe_pkg::alu_slt]  = inst_slt;
    assign ctl.alu_op[pipe_pkg::alu_sltu] = inst_sltu;
    assign ctl.alu_op[pipe_pkg::alu_and]  = inst_and | inst_andi;
    assign ctl.alu_op[pipe_pkg::alu_nor]  = inst_nor;
    assign ctl.alu_op[pipe_pkg::alu_or]   = inst_or | inst_ori;
    assign ctl.alu_op[pipe_pkg::alu_xor]  = inst_xor | inst_xori;
    assign ctl.alu_op[pipe_pkg::alu_sll]  = inst_sll;
    assign ctl.alu_op[pipe_pkg::alu_srl]  = inst_srl;
    assign ctl.alu_op[pipe_pkg::alu_sra]  = inst_sra;
    assign ctl.alu_op[pipe_pkg::alu_lui]  = inst_lui;

    assign ctl.src1_is_sa  = inst_sll | inst_srl | inst_sra;
    assign ctl.src1_is_pc  = inst_jal;
    assign ctl.src2_is_imm = i_alu | inst_lui | inst_lw | inst_sw; // logic imms zero-extend later
    assign ctl.src2_is_8   = inst_jal;

    assign ctl.mem_re = inst_lw;
    assign ctl.mem_we = inst_sw;
    assign ctl.gpr_we = r_alu | ctl.src1_is_sa | i_alu | inst_lui | inst_lw | inst_jal;

    assign dst_is_rt = i_alu | inst_lui | inst_lw;
    assign ctl.dest  = inst_jal  ? isa_pkg::reg_link :
                       dst_is_rt ? iw.i.rt :
                                   iw.r.rd;

    // which sources the stall check must consider
    assign ctl.uses_rs = r_alu | i_alu | inst_lw | inst_sw | inst_beq | inst_bne | inst_jr;
    assign ctl.uses_rt = r_alu | ctl.src1_is_sa | inst_sw | inst_beq | inst_bne;

    assign ctl.is_beq   = inst_beq;
    assign ctl.is_bne   = inst_bne;
    assign ctl.is_j_imm = inst_j | inst_jal;
    assign ctl.is_jr    = inst_jr;

endmodule

`default_nettype wire

//--- design/regfile.sv
`default_nettype none

module regfile (
    input  logic                            clk,
    rf_read_if.bank                         rd,
    input  logic                            we,
    input  logic [pipe_pkg::reg_addr_w-1:0] waddr,
    input  logic [pipe_pkg::word_w-1:0]     wdata
);

    logic [pipe_pkg::word_w-1:0] regs [pipe_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read
    assign rd.rdata1 = (rd.raddr1 == '0) ? '0 : regs[rd.raddr1];
    assign rd.rdata2 = (rd.raddr2 == '0) ? '0 : regs[rd.raddr2];

endmodule

`default_nettype wire

//--- design/operand_bypass.sv
`default_nettype none

module operand_bypass (
    input  logic [pipe_pkg::reg_addr_w-1:0] rs,
    input  logic [pipe_pkg::reg_addr_w-1:0] rt,
    decode_if.sink                          ctl,
    rf_read_if.reader                       rf,
    input  logic [pipe_pkg::reg_addr_w-1:0] es_dest,
    input  logic [pipe_pkg::reg_addr_w-1:0] ms_dest,
    input  logic [pipe_pkg::reg_addr_w-1:0] ws_addr,
    input  logic [pipe_pkg::word_w-1:0]     es_res,
    input  logic [pipe_pkg::word_w-1:0]     ms_res,
    input  logic [pipe_pkg::word_w-1:0]     ws_data,
    input  logic                            es_res_valid,
    input  logic                            ms_res_valid,
    input  logic                            ws_we,
    output logic [pipe_pkg::word_w-1:0]     rs_value,
    output logic [pipe_pkg::word_w-1:0]     rt_value,
    output logic                            ready_go
);

    logic rs_es, rs_ms, rs_ws;
    logic rt_es, rt_ms, rt_ws;
    logic wait_es, wait_ms;

    // a nonzero source equal to dst; dest 0 then never matches
    function automatic logic hit(input logic [pipe_pkg::reg_addr_w-1:0] src,
                                 input logic [pipe_pkg::reg_addr_w-1:0] dst);
        return (src != '0) && (src == dst);
    endfunction

    assign rf.raddr1 = rs;
    assign rf.raddr2 = rt;

    assign rs_es = hit(rs, es_dest);
    assign rs_ms = hit(rs, ms_dest);
    assign rs_ws = hit(rs, ws_addr) && ws_we;
    assign rt_es = hit(rt, es_dest);
    assign rt_ms = hit(rt, ms_dest);
    assign rt_ws = hit(rt, ws_addr) && ws_we;

    // youngest producer wins
    assign rs_value = rs_es ? es_res  :
                      rs_ms ? ms_res  :
                      rs_ws ? ws_data :
                              rf.rdata1;
    assign rt_value = rt_es ? es_res  :
                      rt_ms ? ms_res  :
                      rt_ws ? ws_data :
                              rf.rdata2;

    // result not ready yet, typically a load in flight
    assign wait_es  = ((ctl.uses_rs && rs_es) || (ctl.uses_rt && rt_es)) && !es_res_valid;
    assign wait_ms  = ((ctl.uses_rs && rs_ms) || (ctl.uses_rt && rt_ms)) && !ms_res_valid;
    assign ready_go = !wait_es && !wait_ms;

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`default_nettype none

module branch_unit (
    input  logic                        ds_valid,
    input  logic [pipe_pkg::word_w-1:0] ds_inst,
    input  logic [pipe_pkg::word_w-1:0] ds_pc,
    decode_if.sink                      ctl,
    input  logic [pipe_pkg::word_w-1:0] rs_value,
    input  logic [pipe_pkg::word_w-1:0] rt_value,
    output logic                        br_taken,
    output logic [pipe_pkg::word_w-1:0] br_target
);

    isa_pkg::inst_word_u         iw;
    logic [pipe_pkg::word_w-1:0] pc_plus4;
    logic [pipe_pkg::word_w-1:0] br_offset;
    logic [pipe_pkg::word_w-1:0] jump_target;
    logic                        rs_eq_rt;

    assign iw       = ds_inst;
    assign pc_plus4 = ds_pc + 32'd4; // delay slot address

    assign br_offset   = {{14{iw.i.imm[15]}}, iw.i.imm, 2'b00};
    assign jump_target = {pc_plus4[pipe_pkg::word_w-1 -: 4], iw.j.jidx, 2'b00};

    assign rs_eq_rt = rs_value == rt_value;

    assign br_taken = ds_valid && ((ctl.is_beq && rs_eq_rt)
                                || (ctl.is_bne && !rs_eq_rt)
                                ||  ctl.is_j_imm
                                ||  ctl.is_jr);

    assign br_target = ctl.is_jr    ? rs_value    :
                       ctl.is_j_imm ? jump_target :
                                      pc_plus4 + br_offset; // beq, bne

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    // fetch side
    input  logic                            fs_to_ds_valid,
    input  logic [pipe_pkg::word_w-1:0]     fs_inst,
    input  logic [pipe_pkg::word_w-1:0]     fs_pc,
    output logic                            ds_allowin,
    // execute side, handshake and forwarding
    input  logic                            es_allowin,
    input  logic [pipe_pkg::reg_addr_w-1:0] es_dest,
    input  logic [pipe_pkg::word_w-1:0]     es_res,
    input  logic                            es_res_valid,
    input  logic [pipe_pkg::reg_addr_w-1:0] ms_dest,
    input  logic [pipe_pkg::word_w-1:0]     ms_res,
    input  logic                            ms_res_valid,
    input  logic                            ws_we,
    input  logic [pipe_pkg::reg_addr_w-1:0] ws_addr,
    input  logic [pipe_pkg::word_w-1:0]     ws_data,
    // payload to execute
    output logic                            ds_to_es_valid,
    output logic [pipe_pkg::alu_op_w-1:0]   alu_op,
    output logic                            src1_is_sa,
    output logic                            src1_is_pc,
    output logic                            src2_is_imm,
    output logic                            src2_is_8,
    output logic                            mem_re,
    output logic                            mem_we,
    output logic                            gpr_we,
    output logic [pipe_pkg::reg_addr_w-1:0] dest,
    output logic [15:0]                     imm,
    output logic [pipe_pkg::word_w-1:0]     rs_value,
    output logic [pipe_pkg::word_w-1:0]     rt_value,
    output logic [pipe_pkg::word_w-1:0]     ds_pc_out,
    // redirect to fetch
    output logic                            br_taken,
    output logic [pipe_pkg::word_w-1:0]     br_target
);

    logic                        ds_valid;
    logic                        ready_go;
    logic [pipe_pkg::word_w-1:0] ds_inst;
    logic [pipe_pkg::word_w-1:0] ds_pc;

    decode_if  ctl_if ();
    rf_read_if rf_if ();

    id_input_reg u_id_input_reg (
        .clk, .reset, .fs_to_ds_valid, .fs_inst, .fs_pc,
        .ready_go, .es_allowin, .ds_allowin, .ds_valid, .ds_inst, .ds_pc
    );

    inst_decoder u_inst_decoder (.ds_inst, .ctl(ctl_if.dec));

    regfile u_regfile (
        .clk, .rd(rf_if.bank), .we(ws_we), .waddr(ws_addr), .wdata(ws_data)
    );

    operand_bypass u_operand_bypass (
        .rs(ds_inst[25:21]), .rt(ds_inst[20:16]), .ctl(ctl_if.sink), .rf(rf_if.reader),
        .es_dest, .ms_dest, .ws_addr, .es_res, .ms_res, .ws_data,
        .es_res_valid, .ms_res_valid, .ws_we, .rs_value, .rt_value, .ready_go
    );

    branch_unit u_branch_unit (
        .ds_valid, .ds_inst, .ds_pc, .ctl(ctl_if.sink),
        .rs_value, .rt_value, .br_taken, .br_target
    );

    assign ds_to_es_valid = ds_valid && ready_go;

    assign alu_op      = ctl_if.alu_op;
    assign src1_is_sa  = ctl_if.src1_is_sa;
    assign src1_is_pc  = ctl_if.src1_is_pc;
    assign src2_is_imm = ctl_if.src2_is_imm;
    assign src2_is_8   = ctl_if.src2_is_8;
    assign mem_re      = ctl_if.mem_re;
    assign mem_we      = ctl_if.mem_we;
    assign gpr_we      = ctl_if.gpr_we;
    assign dest        = ctl_if.dest;
    assign imm         = ds_inst[15:0]; // extension is done in execute
    assign ds_pc_out   = ds_pc;

endmodule

`default_nettype wire

//--- verif/decode_stage_properties.sv
`default_nettype none

module decode_stage_properties (
    input logic                            clk,
    input logic                            reset,
    input logic                            ds_allowin,
    input logic                            ds_to_es_valid,
    input logic                            br_taken,
    input logic                            es_allowin,
    input logic [pipe_pkg::alu_op_w-1:0]   alu_op,
    input logic                            src1_is_sa,
    input logic                            src1_is_pc,
    input logic                            src2_is_imm,
    input logic                            src2_is_8,
    input logic                            mem_re,
    input logic                            mem_we,
    input logic                            gpr_we,
    input logic [pipe_pkg::reg_addr_w-1:0] dest,
    input logic [15:0]                     imm,
    input logic [pipe_pkg::word_w-1:0]     ds_pc_out
);

    logic held; // word offered but execute is full

    assign held = ds_to_es_valid && !es_allowin;

    reset_clears: assert property (@(posedge clk)
        reset |=> !ds_to_es_valid && !br_taken && ds_allowin)
        else $error("stage not empty after reset");

    hold_blocks_input: assert property (@(posedge clk) disable iff (reset)
        held |-> !ds_allowin)
        else $error("new word accepted while execute is full");

    // decoded payload must not move under back-pressure
    hold_keeps_payload: assert property (@(posedge clk) disable iff (reset)
        held |=> ds_to_es_valid && $stable(alu_op) && $stable(dest) && $stable(imm)
                 && $stable(ds_pc_out) && $stable(mem_re) && $stable(mem_we)
                 && $stable(gpr_we) && $stable(src1_is_sa) && $stable(src1_is_pc)
                 && $stable(src2_is_imm) && $stable(src2_is_8))
        else $error("payload changed while held");

endmodule

`default_nettype wire

//--- verif/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

    localparam int num_insts  = 64; // register loads plus decoded words
    localparam int clk_period = 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        fs_to_ds_valid, ds_allowin, es_allowin;
    logic [31:0] fs_inst, fs_pc;
    logic [4:0]  es_dest, ms_dest, ws_addr;
    logic [31:0] es_res, ms_res, ws_data;
    logic        es_res_valid, ms_res_valid, ws_we;
    logic        ds_to_es_valid, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8;
    logic        mem_re, mem_we, gpr_we, br_taken;
    logic [11:0] alu_op;
    logic [4:0]  dest;
    logic [15:0] imm;
    logic [31:0] rs_value, rt_value, ds_pc_out, br_target;

    logic [31:0] model [32]; // expected register contents
    logic [31:0] lfsr_state = 32'h5186b866;
    logic [31:0] pc_next = 32'h0000_1000;
    int          errors = 0;

    decode_stage u_decode_stage (.*);

    bind decode_stage decode_stage_properties u_decode_stage_properties (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, sa,
                                           input logic [5:0] fn);
        isa_pkg::inst_word_u iw;
        iw.r.op   = isa_pkg::op_special;
        iw.r.rs   = rs;
        iw.r.rt   = rt;
        iw.r.rd   = rd;
        iw.r.sa   = sa;
        iw.r.func = fn;
        return iw;
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] k);
        isa_pkg::inst_word_u iw;
        iw.i.op  = op;
        iw.i.rs  = rs;
        iw.i.rt  = rt;
        iw.i.imm = k;
        return iw;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // offer a word and return at the drive point after it is accepted
    task automatic send(input logic [31:0] inst, input logic [31:0] pc);
        int waited;
        waited = 0;
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = pc;
        @(negedge clk);
        while (!ds_allowin && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!ds_allowin) begin
            $display("decode stage never accepted the word at pc %h", pc);
            errors++;
        end
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic decode_case(input string name, input logic [31:0] inst, input int alu_bit,
                               input logic imm_sel, input logic sa_sel, input logic re,
                               input logic we, input logic [4:0] exp_dest);
        isa_pkg::inst_word_u iw;
        logic [31:0]         pc;
        iw = inst;
        pc = pc_next;
        send(inst, pc);
        pc_next = pc_next + 32'd4;
        @(negedge clk);
        check_val({name, " alu_op"}, 32'd1 << alu_bit, 32'(alu_op));
        check_val({name, " src2_is_imm"}, 32'(imm_sel), 32'(src2_is_imm));
        check_val({name, " src1_is_sa"}, 32'(sa_sel), 32'(src1_is_sa));
        check_val({name, " src1_is_pc"}, 32'd0, 32'(src1_is_pc));
        check_val({name, " src2_is_8"}, 32'd0, 32'(src2_is_8));
        check_val({name, " mem_re"}, 32'(re), 32'(mem_re));
        check_val({name, " mem_we"}, 32'(we), 32'(mem_we));
        check_val({name, " gpr_we"}, 32'(!we), 32'(gpr_we));
        if (!we) begin // stores have no destination
            check_val({name, " dest"}, 32'(exp_dest), 32'(dest));
        end
        check_val({name, " imm"}, 32'(iw.i.imm), 32'(imm));
        check_val({name, " ds_pc_out"}, pc, ds_pc_out);
        check_val({name, " rs_value"}, model[iw.r.rs], rs_value);
        check_val({name, " rt_value"}, model[iw.r.rt], rt_value);
        @(posedge clk);
        #2;
    endtask

    task automatic branch_case(input string name, input logic [31:0] inst,
                               input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        send(inst, pc);
        @(negedge clk);
        check_val({name, " br_taken"}, 32'(taken), 32'(br_taken));
        if (taken) begin
            check_val({name, " br_target"}, target, br_target);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_pass(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ds_to_es_valid && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!ds_to_es_valid) begin
            $display("%s: stalled word was never passed to execute", name);
            errors++;
        end
    endtask

    initial begin
        #((num_insts * 20 + 200) * clk_period);
        $display("timeout: the run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [4:0]  a, b, c;
        logic [15:0] k;
        logic [25:0] jidx;
        logic [31:0] pc, v;
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        es_allowin     = 1'b1;
        es_dest        = '0;
        ms_dest        = '0;
        ws_addr        = '0;
        es_res         = '0;
        ms_res         = '0;
        ws_data        = '0;
        es_res_valid   = 1'b0;
        ms_res_valid   = 1'b0;
        ws_we          = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_val("reset ds_to_es_valid", 32'd0, 32'(ds_to_es_valid));
        check_val("reset br_taken", 32'd0, 32'(br_taken));
        check_val("reset ds_allowin", 32'd1, 32'(ds_allowin));

        // fill the register file through writeback
        model[0] = '0;
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            #2;
            ws_we    = 1'b1;
            ws_addr  = 5'(r);
            ws_data  = next_bits(32);
            model[r] = ws_data;
        end
        @(posedge clk);
        #2;
        ws_we = 1'b0;

        a = 5'(next_bits(5));
        b = 5'(next_bits(5));
        c = 5'(next_bits(5));
        decode_case("addu", r_word(a, b, c, 0, isa_pkg::fn_addu), pipe_pkg::alu_add, 0, 0, 0, 0, c);
        decode_case("subu", r_word(a, b, c, 0, isa_pkg::fn_subu), pipe_pkg::alu_sub, 0, 0, 0, 0, c);
        decode_case("and", r_word(a, b, c, 0, isa_pkg::fn_and), pipe_pkg::alu_and, 0, 0, 0, 0, c);
        decode_case("or", r_word(a, b, c, 0, isa_pkg::fn_or), pipe_pkg::alu_or, 0, 0, 0, 0, c);
        decode_case("xor", r_word(a, b, c, 0, isa_pkg::fn_xor), pipe_pkg::alu_xor, 0, 0, 0, 0, c);
        decode_case("nor", r_word(a, b, c, 0, isa_pkg::fn_nor), pipe_pkg::alu_nor, 0, 0, 0, 0, c);
        decode_case("slt", r_word(a, b, c, 0, isa_pkg::fn_slt), pipe_pkg::alu_slt, 0, 0, 0, 0, c);
        decode_case("sltu", r_word(a, b, c, 0, isa_pkg::fn_sltu), pipe_pkg::alu_sltu, 0, 0, 0, 0, c);
        decode_case("sll", r_word(0, b, c, 5, isa_pkg::fn_sll), pipe_pkg::alu_sll, 0, 1, 0, 0, c);
        decode_case("srl", r_word(0, b, c, 9, isa_pkg::fn_srl), pipe_pkg::alu_srl, 0, 1, 0, 0, c);
        decode_case("sra", r_word(0, b, c, 31, isa_pkg::fn_sra), pipe_pkg::alu_sra, 0, 1, 0, 0, c);
        decode_case("addu r0", r_word(0, b, c, 0, isa_pkg::fn_addu), pipe_pkg::alu_add, 0, 0, 0, 0, c);

        a = 5'(next_bits(5));
        b = 5'(next_bits(5));
        k = 16'(next_bits(16));
        decode_case("addiu", i_word(isa_pkg::op_addiu, a, b, k), pipe_pkg::alu_add, 1, 0, 0, 0, b);
        decode_case("andi", i_word(isa_pkg::op_andi, a, b, k), pipe_pkg::alu_and, 1, 0, 0, 0, b);
        decode_case("ori", i_word(isa_pkg::op_ori, a, b, k), pipe_pkg::alu_or, 1, 0, 0, 0, b);
        decode_case("xori", i_word(isa_pkg::op_xori, a, b, k), pipe_pkg::alu_xor, 1, 0, 0, 0, b);
        decode_case("lui", i_word(isa_pkg::op_lui, 0, b, k), pipe_pkg::alu_lui, 1, 0, 0, 0, b);
        decode_case("lw", i_word(isa_pkg::op_lw, a, b, k), pipe_pkg::alu_add, 1, 0, 1, 0, b);
        decode_case("sw", i_word(isa_pkg::op_sw, a, b, k), pipe_pkg::alu_add, 1, 0, 0, 1, b);

        // forwarding priority, word held by execute back-pressure
        a = 5'(next_bits(5)) | 5'd1;
        es_allowin = 1'b0;
        send(r_word(a, b, c, 0, isa_pkg::fn_addu), pc_next);
        es_dest      = a;
        es_res       = next_bits(32);
        es_res_valid = 1'b1;
        ms_dest      = a;
        ms_res       = next_bits(32);
        ms_res_valid = 1'b1;
        ws_we        = 1'b1;
        ws_addr      = a;
        ws_data      = next_bits(32);
        @(negedge clk);
        check_val("fwd es", es_res, rs_value);
        check_val("fwd held ds_allowin", 32'd0, 32'(ds_allowin));
        @(posedge clk);
        #2;
        model[a] = ws_data;
        es_dest  = '0;
        @(negedge clk);
        check_val("fwd ms", ms_res, rs_value);
        @(posedge clk);
        #2;
        ms_dest = '0;
        ws_data = next_bits(32); // register file still holds the older value
        @(negedge clk);
        check_val("fwd ws", ws_data, rs_value);
        @(posedge clk);
        #2;
        model[a]   = ws_data;
        ws_we      = 1'b0;
        es_allowin = 1'b1;
        @(negedge clk);
        check_val("fwd regfile", model[a], rs_value);
        @(posedge clk);
        #2;

        // destination 0 is never a producer
        send(r_word(0, b, c, 0, isa_pkg::fn_addu), pc_next);
        es_dest = '0;
        es_res  = next_bits(32);
        @(negedge clk);
        check_val("fwd r0", 32'd0, rs_value);
        @(posedge clk);
        #2;
        es_res_valid = 1'b0;
        ms_res_valid = 1'b0;

        // load-use stall on rs
        a       = 5'(next_bits(5)) | 5'd1;
        v       = next_bits(32);
        es_dest = a;
        es_res  = v;
        send(r_word(a, b, c, 0, isa_pkg::fn_addu), pc_next);
        repeat (2) begin
            @(negedge clk);
            check_val("stall ds_to_es_valid", 32'd0, 32'(ds_to_es_valid));
            check_val("stall ds_allowin", 32'd0, 32'(ds_allowin));
            @(posedge clk);
            #2;
        end
        es_res_valid = 1'b1;
        wait_pass("stall");
        check_val("stall rs_value", v, rs_value);
        @(posedge clk);
        #2;
        es_dest      = '0;
        es_res_valid = 1'b0;

        // branches and jumps
        a    = 5'(next_bits(5));
        b    = 5'(next_bits(5));
        k    = 16'(next_bits(16));
        jidx = 26'(next_bits(26));
        pc   = next_bits(30) << 2;
        v    = pc + 32'd4 + ({{16{k[15]}}, k} << 2);
        branch_case("beq equal", i_word(isa_pkg::op_beq, a, a, k), pc, 1, v);
        branch_case("beq", i_word(isa_pkg::op_beq, a, b, k), pc, model[a] == model[b], v);
        branch_case("bne", i_word(isa_pkg::op_bne, a, b, k), pc, model[a] != model[b], v);
        v = {pc[31:28] + 4'(pc[27:2] == '1), jidx, 2'b00};
        branch_case("j", {isa_pkg::op_j, jidx}, pc, 1, v);
        branch_case("jal", {isa_pkg::op_jal, jidx}, pc, 1, v);
        branch_case("jr", r_word(a, 0, 0, 0, isa_pkg::fn_jr), pc, 1, model[a]);
        send({isa_pkg::op_jal, jidx}, pc);
        @(negedge clk);
        check_val("jal dest", 32'd31, 32'(dest));
        check_val("jal gpr_we", 32'd1, 32'(gpr_we));
        check_val("jal src1_is_pc", 32'd1, 32'(src1_is_pc));
        check_val("jal src2_is_8", 32'd1, 32'(src2_is_8));

        repeat (3) @(posedge clk);
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/pipe_pkg.sv
design/isa_pkg.sv
design/stage_ifs.sv
design/id_input_reg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/decode_stage.sv
verif/decode_stage_properties.sv
verif/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_decode_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
exit 1
